// ==== bnn_pkg.sv ====
`default_nettype none

package bnn_pkg;

  // ==============================
  // Image and buffer sizing
  // ==============================
  localparam int IMG_BYTES = 113;        // Bytes per image
  localparam int ADDR_W    = 7;          // Buffer address width

  // ==============================
  // SPI command bytes
  // ==============================
  localparam logic [7:0] CMD_IMG_SEND = 8'hFE;  // Image follows
  localparam logic [7:0] CMD_CLEAR    = 8'hFD;  // Drop buffer and result

  // ==============================
  // Status codes
  // ==============================
  localparam logic [3:0] STATUS_IDLE       = 4'd0;
  localparam logic [3:0] STATUS_RX_IMG_RDY = 4'd1;   // Waiting for first image byte
  localparam logic [3:0] STATUS_RX_IMG     = 4'd2;   // Image bytes arriving
  localparam logic [3:0] STATUS_BNN_BUSY   = 4'd4;
  localparam logic [3:0] STATUS_RESULT_RDY = 4'd8;
  localparam logic [3:0] STATUS_ERROR      = 4'd14;

  // ==============================
  // Classifier
  // ==============================
  localparam int N_CLASSES = 4;
  localparam int SCORE_W   = 10;         // Max score is 113 * 8 = 904

  // Key byte per class, class 0 in the low byte
  localparam logic [N_CLASSES-1:0][7:0] CLASS_KEY = {8'h0F, 8'hAA, 8'hFF, 8'h00};

  // Idle clk cycles tolerated between image bytes
  localparam int GAP_LIMIT = 2000;
  localparam int GAP_CNT_W = $clog2(GAP_LIMIT + 1);

endpackage

`default_nettype wire

// ==== spi_byte_rx.sv ====
`default_nettype none
`timescale 1ns/1ps

module spi_byte_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sclk,
  input  logic       cs_n,
  input  logic       mosi,
  input  logic       rx_enable,
  input  logic       byte_taken,
  input  logic [7:0] status_word,
  output logic [7:0] rx_data,
  output logic       byte_valid,
  output logic       miso
);

  logic [1:0] sclk_sync;
  logic [1:0] cs_sync;
  logic [1:0] mosi_sync;
  logic       sclk_q;
  logic       cs_q;
  logic       sclk_rise;
  logic       sclk_fall;
  logic       cs_fall;
  logic       byte_done;
  logic [2:0] bit_cnt;
  logic [7:0] rx_shift;
  logic [7:0] tx_shift;

  assign sclk_rise = sclk_sync[1] && !sclk_q;
  assign sclk_fall = !sclk_sync[1] && sclk_q;
  assign cs_fall   = !cs_sync[1] && cs_q;
  assign byte_done = sclk_rise && !cs_sync[1] && (bit_cnt == 3'd7);
  assign miso      = tx_shift[7];                  // MSB first

  // ==============================
  // Synchronizers, bit count, status shifter
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sclk_sync  <= 2'b00;
      cs_sync    <= 2'b11;                          // Deselected at reset
      mosi_sync  <= 2'b00;
      sclk_q     <= 1'b0;
      cs_q       <= 1'b1;
      bit_cnt    <= 3'd0;
      byte_valid <= 1'b0;
      tx_shift   <= 8'h00;
    end else begin
      sclk_sync <= {sclk_sync[0], sclk};
      cs_sync   <= {cs_sync[0], cs_n};
      mosi_sync <= {mosi_sync[0], mosi};
      sclk_q    <= sclk_sync[1];
      cs_q      <= cs_sync[1];

      if (cs_sync[1])
        bit_cnt <= 3'd0;
      else if (sclk_rise)
        bit_cnt <= bit_cnt + 1'b1;

      // Bytes finished while disabled are dropped
      if (byte_done && rx_enable)
        byte_valid <= 1'b1;
      else if (byte_taken)
        byte_valid <= 1'b0;

      if (cs_fall)
        tx_shift <= status_word;                   // Snapshot at start of transfer
      else if (sclk_fall && !cs_sync[1])
        tx_shift <= {tx_shift[6:0], 1'b0};
    end
  end

  always_ff @(posedge clk) begin
    if (sclk_rise)
      rx_shift <= {rx_shift[6:0], mosi_sync[1]};
    if (byte_done && rx_enable)
      rx_data <= {rx_shift[6:0], mosi_sync[1]};
  end

endmodule

`default_nettype wire

// ==== controller_fsm.sv ====
`default_nettype none
`timescale 1ns/1ps

module controller_fsm (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic [7:0]                 rx_data,
  input  logic                       byte_valid,
  output logic                       byte_taken,
  output logic                       rx_enable,
  input  logic                       buf_full,
  input  logic                       buf_empty,
  input  logic                       wr_ready,
  output logic                       wr_req,
  output logic                       clear,
  output logic [7:0]                 wr_data,
  output logic [bnn_pkg::ADDR_W-1:0] wr_addr,
  input  logic                       gap_expired,
  output logic                       gap_run,
  output logic                       gap_restart,
  input  logic                       result_ready,
  input  logic [3:0]                 class_in,
  output logic                       bnn_enable,
  output logic [3:0]                 status_code,
  output logic [3:0]                 result
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_WAIT_IMAGE,
    S_IMG_RX,
    S_WAIT_FOR_BNN,
    S_RESULT_RDY,
    S_CLEAR
  } state_t;

  state_t     state;
  state_t     next_state;
  logic [3:0] next_status;
  logic       valid_q;
  logic       new_byte;
  logic       buf_full_q;

  assign new_byte    = byte_valid && !valid_q;     // Rising edge only
  assign wr_data     = rx_data;
  assign gap_run     = (state == S_IMG_RX);
  assign gap_restart = wr_req && wr_ready;

  // ==============================
  // State, status, address, result
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state       <= S_IDLE;
      status_code <= bnn_pkg::STATUS_IDLE;
      result      <= 4'd0;
      wr_addr     <= '0;
      byte_taken  <= 1'b0;
      valid_q     <= 1'b0;
      buf_full_q  <= 1'b0;
    end else begin
      state       <= next_state;
      status_code <= next_status;
      byte_taken  <= new_byte;                     // Every new byte is consumed
      valid_q     <= byte_valid;
      buf_full_q  <= buf_full;

      if (clear)
        wr_addr <= '0;
      else if (wr_req && wr_ready)
        wr_addr <= wr_addr + 1'b1;

      if (clear)
        result <= 4'd0;
      else if (state == S_WAIT_FOR_BNN && result_ready)
        result <= class_in;                        // Captured on entry to S_RESULT_RDY
    end
  end

  // ==============================
  // Next state
  // ==============================
  always_comb begin
    next_state  = state;
    next_status = status_code;
    rx_enable   = 1'b1;
    wr_req      = 1'b0;
    clear       = 1'b0;
    bnn_enable  = 1'b0;

    case (state)
      S_IDLE: begin
        if (buf_full_q) begin
          next_state  = S_WAIT_FOR_BNN;
          next_status = bnn_pkg::STATUS_BNN_BUSY;
        end else if (new_byte) begin
          if (rx_data == bnn_pkg::CMD_CLEAR) begin
            next_state  = S_CLEAR;
            next_status = bnn_pkg::STATUS_IDLE;
            clear       = 1'b1;
          end else if (rx_data == bnn_pkg::CMD_IMG_SEND) begin
            next_state  = S_WAIT_IMAGE;
            next_status = bnn_pkg::STATUS_RX_IMG_RDY;
          end else if (wr_ready) begin
            wr_req = 1'b1;                         // Raw byte goes straight to buffer
          end else begin
            next_status = bnn_pkg::STATUS_ERROR;
          end
        end
      end

      S_WAIT_IMAGE: begin
        if (new_byte) begin
          next_state  = S_IMG_RX;
          next_status = bnn_pkg::STATUS_RX_IMG;
          wr_req      = 1'b1;
        end
      end

      S_IMG_RX: begin
        if (buf_full_q) begin
          next_state  = S_WAIT_FOR_BNN;
          next_status = bnn_pkg::STATUS_BNN_BUSY;
        end else if (gap_expired) begin
          next_state  = S_IDLE;                    // Host stalled mid image
          next_status = bnn_pkg::STATUS_ERROR;
        end else if (new_byte) begin
          if (rx_data == bnn_pkg::CMD_CLEAR) begin
            next_state  = S_CLEAR;
            next_status = bnn_pkg::STATUS_IDLE;
            clear       = 1'b1;
          end else begin
            wr_req = 1'b1;
          end
        end
      end

      S_WAIT_FOR_BNN: begin
        bnn_enable = 1'b1;
        if (result_ready) begin
          next_state  = S_RESULT_RDY;
          next_status = bnn_pkg::STATUS_RESULT_RDY;
        end else if (new_byte && rx_data == bnn_pkg::CMD_CLEAR) begin
          next_state  = S_CLEAR;
          next_status = bnn_pkg::STATUS_IDLE;
          clear       = 1'b1;
        end
      end

      S_RESULT_RDY: begin
        if (new_byte && rx_data == bnn_pkg::CMD_CLEAR) begin
          next_state  = S_CLEAR;
          next_status = bnn_pkg::STATUS_IDLE;
          clear       = 1'b1;
        end
      end

      S_CLEAR: begin
        rx_enable = 1'b0;
        clear     = 1'b1;
        if (buf_empty) begin
          next_state  = S_IDLE;
          next_status = bnn_pkg::STATUS_IDLE;
        end
      end

      default: begin
        next_state  = S_IDLE;
        next_status = bnn_pkg::STATUS_ERROR;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== byte_gap_timer.sv ====
`default_nettype none
`timescale 1ns/1ps

module byte_gap_timer (
  input  logic clk,
  input  logic rst_n,
  input  logic run,
  input  logic restart,
  output logic expired
);

  logic [bnn_pkg::GAP_CNT_W-1:0] cnt;

  assign expired = (int'(cnt) == bnn_pkg::GAP_LIMIT);

  // Saturates at the limit so expired stays up
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      cnt <= '0;
    else if (restart || !run)
      cnt <= '0;
    else if (!expired)
      cnt <= cnt + 1'b1;
  end

endmodule

`default_nettype wire

// ==== image_buffer.sv ====
`default_nettype none
`timescale 1ns/1ps

module image_buffer (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       wr_req,
  input  logic [bnn_pkg::ADDR_W-1:0] wr_addr,
  input  logic [7:0]                 wr_data,
  input  logic                       clear,
  input  logic [bnn_pkg::ADDR_W-1:0] rd_addr,
  output logic [7:0]                 rd_data,
  output logic                       wr_ready,
  output logic                       full,
  output logic                       empty
);

  logic [7:0]                 mem [bnn_pkg::IMG_BYTES];
  logic [bnn_pkg::ADDR_W-1:0] fill;
  logic                       wr_fire;

  assign full     = (int'(fill) == bnn_pkg::IMG_BYTES);
  assign empty    = (fill == '0);
  assign wr_ready = !full;
  assign wr_fire  = wr_req && wr_ready && !clear;

  // Fill count, clear wins over a write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n)
      fill <= '0;
    else if (clear)
      fill <= '0;
    else if (wr_fire)
      fill <= fill + 1'b1;
  end

  // Storage with registered read
  always_ff @(posedge clk) begin
    if (wr_fire)
      mem[wr_addr] <= wr_data;
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== bnn_engine.sv ====
`default_nettype none
`timescale 1ns/1ps

module bnn_engine (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       enable,
  output logic [bnn_pkg::ADDR_W-1:0] rd_addr,
  input  logic [7:0]                 rd_data,
  output logic                       result_ready,
  output logic [3:0]                 class_out
);

  typedef enum logic [1:0] {
    E_IDLE,
    E_SCAN,
    E_PICK,
    E_DONE
  } eng_state_t;

  eng_state_t                  state;
  logic                        last_q;             // Last byte on rd_data this cycle
  logic [bnn_pkg::SCORE_W-1:0] score [bnn_pkg::N_CLASSES];
  logic [bnn_pkg::SCORE_W-1:0] best_score;
  logic [3:0]                  best_idx;

  function automatic logic [bnn_pkg::SCORE_W-1:0] popcount(input logic [7:0] b);
    logic [bnn_pkg::SCORE_W-1:0] n;
    n = '0;
    for (int i = 0; i < 8; i++) begin
      if (b[i])
        n = n + 1'b1;
    end
    return n;
  endfunction

  // Strict greater keeps the lower index on a tie
  always_comb begin
    best_idx   = 4'd0;
    best_score = score[0];
    for (int c = 1; c < bnn_pkg::N_CLASSES; c++) begin
      if (score[c] > best_score) begin
        best_idx   = 4'(c);
        best_score = score[c];
      end
    end
  end

  // ==============================
  // Scan sequencing
  // ==============================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state        <= E_IDLE;
      rd_addr      <= '0;
      last_q       <= 1'b0;
      result_ready <= 1'b0;
      class_out    <= 4'd0;
    end else if (!enable) begin
      state        <= E_IDLE;                      // Abort or release after result
      rd_addr      <= '0;
      last_q       <= 1'b0;
      result_ready <= 1'b0;
    end else begin
      case (state)
        E_IDLE: begin
          state   <= E_SCAN;
          rd_addr <= rd_addr + 1'b1;               // Address 0 already issued
        end
        E_SCAN: begin
          last_q <= (int'(rd_addr) == bnn_pkg::IMG_BYTES - 1) && !last_q;
          if (int'(rd_addr) != bnn_pkg::IMG_BYTES - 1)
            rd_addr <= rd_addr + 1'b1;
          if (last_q)
            state <= E_PICK;
        end
        E_PICK: begin
          result_ready <= 1'b1;
          class_out    <= best_idx;
          state        <= E_DONE;
        end
        default: state <= E_DONE;                  // Hold until enable drops
      endcase
    end
  end

  // XNOR popcount accumulation, one byte per scan cycle
  always_ff @(posedge clk) begin
    for (int c = 0; c < bnn_pkg::N_CLASSES; c++) begin
      if (state == E_IDLE)
        score[c] <= '0;
      else if (state == E_SCAN)
        score[c] <= score[c] + popcount(~(rd_data ^ bnn_pkg::CLASS_KEY[c]));
    end
  end

endmodule

`default_nettype wire

// ==== bnn_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module bnn_top (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       sclk,
  input  logic       cs_n,
  input  logic       mosi,
  output logic       miso,
  output logic [3:0] status_code,
  output logic [3:0] result
);

  logic [7:0]                 rx_data;
  logic                       byte_valid;
  logic                       byte_taken;
  logic                       rx_enable;
  logic                       wr_req;
  logic                       wr_ready;
  logic                       clear;
  logic                       buf_full;
  logic                       buf_empty;
  logic [7:0]                 wr_data;
  logic [7:0]                 rd_data;
  logic [bnn_pkg::ADDR_W-1:0] wr_addr;
  logic [bnn_pkg::ADDR_W-1:0] rd_addr;
  logic                       gap_run;
  logic                       gap_restart;
  logic                       gap_expired;
  logic                       bnn_enable;
  logic                       result_ready;
  logic [3:0]                 class_out;

  // ==============================
  // SPI front end
  // ==============================
  spi_byte_rx u_rx (
    .clk         (clk),
    .rst_n       (rst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .rx_enable   (rx_enable),
    .byte_taken  (byte_taken),
    .status_word ({result, status_code}),          // Read back by the host
    .rx_data     (rx_data),
    .byte_valid  (byte_valid),
    .miso        (miso)
  );

  controller_fsm u_fsm (
    .clk          (clk),
    .rst_n        (rst_n),
    .rx_data      (rx_data),
    .byte_valid   (byte_valid),
    .byte_taken   (byte_taken),
    .rx_enable    (rx_enable),
    .buf_full     (buf_full),
    .buf_empty    (buf_empty),
    .wr_ready     (wr_ready),
    .wr_req       (wr_req),
    .clear        (clear),
    .wr_data      (wr_data),
    .wr_addr      (wr_addr),
    .gap_expired  (gap_expired),
    .gap_run      (gap_run),
    .gap_restart  (gap_restart),
    .result_ready (result_ready),
    .class_in     (class_out),
    .bnn_enable   (bnn_enable),
    .status_code  (status_code),
    .result       (result)
  );

  byte_gap_timer u_timer (
    .clk     (clk),
    .rst_n   (rst_n),
    .run     (gap_run),
    .restart (gap_restart),
    .expired (gap_expired)
  );

  // ==============================
  // Storage and classifier
  // ==============================
  image_buffer u_buf (
    .clk      (clk),
    .rst_n    (rst_n),
    .wr_req   (wr_req),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .clear    (clear),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data),
    .wr_ready (wr_ready),
    .full     (buf_full),
    .empty    (buf_empty)
  );

  bnn_engine u_bnn (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable       (bnn_enable),
    .rd_addr      (rd_addr),
    .rd_data      (rd_data),
    .result_ready (result_ready),
    .class_out    (class_out)
  );

endmodule

`default_nettype wire

// ==== bnn_properties.sv ====
`default_nettype none
`timescale 1ns/1ps

module bnn_properties (
  input logic clk,
  input logic rst_n,
  input logic bnn_enable,
  input logic wr_req,
  input logic clear,
  input logic byte_taken
);

  // Buffer is read by the classifier, no writes during a scan
  a_no_write_in_scan: assert property (@(posedge clk) disable iff (!rst_n)
    !(bnn_enable && wr_req))
    else $error("wr_req high while bnn_enable is high");

  a_clear_no_write: assert property (@(posedge clk) disable iff (!rst_n)
    clear |-> !wr_req)
    else $error("wr_req high during clear");

  a_taken_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    byte_taken |=> !byte_taken)                  // One cycle per byte
    else $error("byte_taken high for more than one cycle");

endmodule

bind controller_fsm bnn_properties u_props (
  .clk        (clk),
  .rst_n      (rst_n),
  .bnn_enable (bnn_enable),
  .wr_req     (wr_req),
  .clear      (clear),
  .byte_taken (byte_taken)
);

`default_nettype wire

// ==== tb_bnn_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_bnn_top;

  localparam int          CLK_HALF    = 20;
  localparam int          DRIVE_DLY   = 2;       // Inputs change just after posedge
  localparam int          RESET_CYC   = 4;
  localparam int          PHASE_CYC   = 4;       // clk cycles per sclk phase
  localparam int          STALL_CYC   = 3000;
  localparam int          N_IMAGES    = 4;       // Images expected to classify
  localparam logic [15:0] LFSR_SEED   = 16'd41748;
  // About 64 cycles per byte, five images of 114 bytes plus stall, wide margin
  localparam int          TIMEOUT_CYC = 150000;

  logic       clk;
  logic       rst_n;
  logic       sclk;
  logic       cs_n;
  logic       mosi;
  logic       miso;
  logic [3:0] status_code;
  logic [3:0] result;

  logic [7:0]  img [bnn_pkg::IMG_BYTES];
  logic [15:0] lfsr;
  logic [3:0]  exp_class;
  logic [3:0]  prev_status = 4'd0;
  int          errors = 0;
  int          checks = 0;
  int          results_seen = 0;
  int          cycles = 0;

  bnn_top u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .mosi        (mosi),
    .miso        (miso),
    .status_code (status_code),
    .result      (result)
  );

  always #(CLK_HALF) clk = ~clk;

  // ==============================
  // Helpers
  // ==============================
  task automatic check(input string name, input int expected, input int actual);
    checks++;
    if (actual != expected) begin
      errors++;
      $display("CHECK FAILED: %s expected 0x%0h actual 0x%0h", name, expected, actual);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #(DRIVE_DLY);
  endtask

  // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0])
      return (s >> 1) ^ 16'hB400;
    return s >> 1;
  endfunction

  task automatic take_random_byte(output logic [7:0] b);
    b = 8'h00;
    for (int i = 0; i < 8; i++) begin
      b    = {b[6:0], lfsr[0]};                    // One step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // 0xFD inside an image reads as a clear command, so it is skipped
  task automatic fill_random_image();
    logic [7:0] b;
    for (int i = 0; i < bnn_pkg::IMG_BYTES; i++) begin
      do begin
        take_random_byte(b);
      end while (b == 8'hFD);
      img[i] = b;
    end
  endtask

  // Count of matching bits per key, highest count wins, ties to lower class
  function automatic logic [3:0] expected_class();
    logic [7:0] keys [4];
    int         score [4];
    int         best;
    keys = '{8'h00, 8'hFF, 8'hAA, 8'h0F};
    for (int c = 0; c < 4; c++)
      score[c] = 0;
    for (int i = 0; i < bnn_pkg::IMG_BYTES; i++) begin
      for (int c = 0; c < 4; c++) begin
        for (int k = 0; k < 8; k++) begin
          if (img[i][k] == keys[c][k])
            score[c]++;
        end
      end
    end
    best = 0;
    for (int c = 1; c < 4; c++) begin
      if (score[c] > score[best])
        best = c;
    end
    return 4'(best);
  endfunction

  // ==============================
  // SPI mode 0 host
  // ==============================
  task automatic spi_transfer(input logic [7:0] tx, output logic [7:0] rx);
    rx   = 8'h00;
    cs_n = 1'b0;
    wait_cycles(PHASE_CYC);
    for (int i = 7; i >= 0; i--) begin
      mosi = tx[i];
      wait_cycles(PHASE_CYC);
      rx[i] = miso;                                // Sampled at the rising sclk edge
      sclk  = 1'b1;
      wait_cycles(PHASE_CYC);
      sclk  = 1'b0;
    end
    wait_cycles(PHASE_CYC);
    cs_n = 1'b1;
    wait_cycles(PHASE_CYC);
  endtask

  task automatic send_byte(input logic [7:0] b);
    logic [7:0] unused_rx;
    spi_transfer(b, unused_rx);
  endtask

  task automatic wait_status(input string name, input logic [3:0] code, input int limit);
    int n;
    n = 0;
    while (status_code !== code && n < limit) begin
      wait_cycles(1);
      n++;
    end
    check(name, int'(code), int'(status_code));
  endtask

  task automatic run_image();
    exp_class = expected_class();
    send_byte(bnn_pkg::CMD_IMG_SEND);
    wait_status("status after image command", bnn_pkg::STATUS_RX_IMG_RDY, 16);
    send_byte(img[0]);
    wait_status("status after first image byte", bnn_pkg::STATUS_RX_IMG, 16);
    for (int i = 1; i < bnn_pkg::IMG_BYTES; i++)
      send_byte(img[i]);
    wait_status("classifier busy", bnn_pkg::STATUS_BNN_BUSY, 16);
    wait_status("result ready", bnn_pkg::STATUS_RESULT_RDY, bnn_pkg::IMG_BYTES + 16);
  endtask

  task automatic clear_and_check();
    send_byte(bnn_pkg::CMD_CLEAR);
    wait_status("status after clear", bnn_pkg::STATUS_IDLE, 16);
    check("result after clear", 0, int'(result));
  endtask

  // A zero byte is ignored while the result is shown
  task automatic read_status_word();
    logic [7:0] expected;
    logic [7:0] got;
    expected = {exp_class, bnn_pkg::STATUS_RESULT_RDY};  // Result state as cs_n falls
    spi_transfer(8'h00, got);
    check("miso status readback", int'(expected), int'(got));
  endtask

  // ==============================
  // Result compare and timeout
  // ==============================
  always @(negedge clk) begin
    if (rst_n && status_code == bnn_pkg::STATUS_RESULT_RDY &&
        prev_status != bnn_pkg::STATUS_RESULT_RDY) begin
      results_seen++;
      check("classifier result", int'(exp_class), int'(result));
    end
    prev_status = status_code;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYC) begin
      $display("Timeout: no end of test within %0d cycles", TIMEOUT_CYC);
      $display("Checks: %0d  errors: %0d", checks, errors + 1);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // ==============================
  // Stimulus
  // ==============================
  initial begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    sclk      = 1'b0;
    cs_n      = 1'b1;
    mosi      = 1'b0;
    lfsr      = LFSR_SEED;
    exp_class = 4'd0;
    wait_cycles(RESET_CYC);
    rst_n = 1'b1;
    wait_cycles(2);
    check("status after reset", int'(bnn_pkg::STATUS_IDLE), int'(status_code));
    check("result after reset", 0, int'(result));

    for (int n = 0; n < 3; n++) begin
      fill_random_image();
      run_image();
      if (n == 0)
        read_status_word();
      clear_and_check();                           // Next image must start at address 0
    end

    // Host stalls part way through an image
    fill_random_image();
    send_byte(bnn_pkg::CMD_IMG_SEND);
    wait_status("status before stall", bnn_pkg::STATUS_RX_IMG_RDY, 16);
    for (int i = 0; i < 10; i++)
      send_byte(img[i]);
    wait_status("status after byte gap stall", bnn_pkg::STATUS_ERROR, STALL_CYC);
    clear_and_check();

    for (int i = 0; i < bnn_pkg::IMG_BYTES; i++)
      img[i] = 8'hAA;
    run_image();
    clear_and_check();

    check("results compared", N_IMAGES, results_seen);
    $display("Checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
bnn_pkg.sv
spi_byte_rx.sv
controller_fsm.sv
byte_gap_timer.sv
image_buffer.sv
bnn_engine.sv
bnn_top.sv
bnn_properties.sv
tb_bnn_top.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := tb_bnn_top
FILELIST := compile.f
OBJDIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf $(OBJDIR)
